// ==== hdl/decode_stage.sv ====
/* decode stage */

`timescale 1ns/1ps

module decode_stage
(
    input  logic                              SYS_clk,
    input  logic                              SYS_reset,
    input  logic                              instr_valid,
    input  logic [mips_pkg::XLEN-1:0]         instr,
    input  logic                              flush,
    input  logic [mips_pkg::XLEN-1:0]         rs_val,
    input  logic [mips_pkg::XLEN-1:0]         rt_val,
    output logic                              d_valid,
    output mips_pkg::alu_op_t                 d_alu_op,
    output logic [mips_pkg::REG_ADDR_W-1:0]   d_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0]   d_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0]   d_dest,
    output logic [mips_pkg::XLEN-1:0]         d_imm,
    output logic                              d_use_imm,
    output logic                              d_mem_read,
    output logic                              d_mem_write,
    output logic                              d_reg_write,
    output mips_pkg::exc_cause_t              d_cause,
    output logic [mips_pkg::XLEN-1:0]         d_pc,
    output logic [mips_pkg::XLEN-1:0]         d_rs_val,
    output logic [mips_pkg::XLEN-1:0]         d_rt_val
);

    logic [mips_pkg::XLEN-1:0] pc_cnt;
    logic [mips_pkg::XLEN-1:0] instr_q;
    mips_pkg::opcode_t         opcode;
    mips_pkg::funct_t          funct;
    logic                      illegal;
    logic                      mem_read;
    logic                      mem_write;
    logic                      reg_write;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset || flush)
        begin
            pc_cnt  <= mips_pkg::PC_BASE;
            d_valid <= 1'b0;
            instr_q <= '0;
        end
        else
        begin
            d_valid <= instr_valid;
            instr_q <= instr_valid ? instr : '0;  // idle slot decodes as nop
            if (instr_valid)
            begin
                d_pc   <= pc_cnt;
                pc_cnt <= pc_cnt + mips_pkg::PC_STEP;
            end
        end
    end

    assign opcode = mips_pkg::opcode_t'(instr_q[31:26]);
    assign funct  = mips_pkg::funct_t'(instr_q[5:0]);

    always_comb
    begin
        d_alu_op  = mips_pkg::alu_add;
        d_use_imm = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            mips_pkg::op_rtype:
            begin
                reg_write = (instr_q != '0);  // all-zero word is a nop
                case (funct)
                    mips_pkg::fn_add: d_alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_sub: d_alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and: d_alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:  d_alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt: d_alu_op = mips_pkg::alu_slt;
                    default:          illegal  = (instr_q != '0);
                endcase
            end
            mips_pkg::op_addi:
            begin
                d_use_imm = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::op_lw:
            begin
                d_use_imm = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::op_sw:
            begin
                d_use_imm = 1'b1;
                mem_write = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    assign d_rs        = instr_q[25:21];
    assign d_rt        = instr_q[20:16];
    assign d_dest      = (opcode == mips_pkg::op_rtype) ? instr_q[15:11] : instr_q[20:16];
    assign d_imm       = {{(mips_pkg::XLEN-16){instr_q[15]}}, instr_q[15:0]};
    assign d_cause     = illegal ? mips_pkg::exc_illegal : mips_pkg::exc_none;
    assign d_reg_write = reg_write && !illegal;
    assign d_mem_read  = mem_read && !illegal;
    assign d_mem_write = mem_write && !illegal;
    assign d_rs_val    = rs_val;  // register file read, write-through included
    assign d_rt_val    = rt_val;

    // cause must be resolved for every instruction entering execute
    a_cause_known: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        d_valid |-> !$isunknown(d_cause));

endmodule

// ==== hdl/execute_stage.sv ====
/* execute stage with forwarding */

`timescale 1ns/1ps

module execute_stage
(
    input  logic                              SYS_clk,
    input  logic                              SYS_reset,
    input  logic                              flush,
    input  logic                              d_valid,
    input  mips_pkg::alu_op_t                 d_alu_op,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   d_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   d_rt,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   d_dest,
    input  logic [mips_pkg::XLEN-1:0]         d_imm,
    input  logic                              d_use_imm,
    input  logic                              d_mem_read,
    input  logic                              d_mem_write,
    input  logic                              d_reg_write,
    input  mips_pkg::exc_cause_t              d_cause,
    input  logic [mips_pkg::XLEN-1:0]         d_pc,
    input  logic [mips_pkg::XLEN-1:0]         d_rs_val,
    input  logic [mips_pkg::XLEN-1:0]         d_rt_val,
    input  logic                              m_reg_write,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   m_dest,
    input  logic [mips_pkg::XLEN-1:0]         m_alu_result,
    input  logic                              wb_valid,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   wb_reg,
    input  logic [mips_pkg::XLEN-1:0]         wb_data,
    output logic                              e_valid,
    output logic [mips_pkg::XLEN-1:0]         e_alu_result,
    output logic [mips_pkg::XLEN-1:0]         e_store_data,
    output logic [mips_pkg::REG_ADDR_W-1:0]   e_dest,
    output logic                              e_mem_read,
    output logic                              e_mem_write,
    output logic                              e_reg_write,
    output mips_pkg::exc_cause_t              e_cause,
    output logic [mips_pkg::XLEN-1:0]         e_pc
);

    localparam int MSB = mips_pkg::XLEN - 1;

    mips_pkg::alu_op_t               alu_op;
    mips_pkg::exc_cause_t            cause_q;
    logic [mips_pkg::REG_ADDR_W-1:0] rs_q;
    logic [mips_pkg::REG_ADDR_W-1:0] rt_q;
    logic [mips_pkg::XLEN-1:0]       imm_q;
    logic [mips_pkg::XLEN-1:0]       rs_val_q;
    logic [mips_pkg::XLEN-1:0]       rt_val_q;
    logic                            use_imm;
    logic                            mem_read_q;
    logic                            mem_write_q;
    logic                            reg_write_q;
    logic [mips_pkg::XLEN-1:0]       op_a;
    logic [mips_pkg::XLEN-1:0]       op_b;
    logic [mips_pkg::XLEN-1:0]       alu_b;
    logic                            overflow;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset || flush)
        begin
            e_valid     <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            reg_write_q <= 1'b0;
            cause_q     <= mips_pkg::exc_none;
        end
        else
        begin
            e_valid     <= d_valid;
            mem_read_q  <= d_mem_read;
            mem_write_q <= d_mem_write;
            reg_write_q <= d_reg_write;
            cause_q     <= d_cause;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        alu_op   <= d_alu_op;
        rs_q     <= d_rs;
        rt_q     <= d_rt;
        e_dest   <= d_dest;
        imm_q    <= d_imm;
        use_imm  <= d_use_imm;
        rs_val_q <= d_rs_val;
        rt_val_q <= d_rt_val;
        e_pc     <= d_pc;
    end

    // memory stage is younger so it wins over writeback
    assign op_a = (m_reg_write && m_dest != '0 && m_dest == rs_q) ? m_alu_result :
                  (wb_valid && wb_reg != '0 && wb_reg == rs_q)    ? wb_data : rs_val_q;
    assign op_b = (m_reg_write && m_dest != '0 && m_dest == rt_q) ? m_alu_result :
                  (wb_valid && wb_reg != '0 && wb_reg == rt_q)    ? wb_data : rt_val_q;
    assign alu_b = use_imm ? imm_q : op_b;

    always_comb
    begin
        case (alu_op)
            mips_pkg::alu_sub: e_alu_result = op_a - alu_b;
            mips_pkg::alu_and: e_alu_result = op_a & alu_b;
            mips_pkg::alu_or:  e_alu_result = op_a | alu_b;
            mips_pkg::alu_slt: e_alu_result = {{MSB{1'b0}}, $signed(op_a) < $signed(alu_b)};
            default:           e_alu_result = op_a + alu_b;  // add, addi, lw, sw
        endcase
    end

    // address arithmetic of lw and sw never traps
    assign overflow = !(mem_read_q || mem_write_q) &&
        ((alu_op == mips_pkg::alu_add && op_a[MSB] == alu_b[MSB] &&
          e_alu_result[MSB] != op_a[MSB]) ||
         (alu_op == mips_pkg::alu_sub && op_a[MSB] != alu_b[MSB] &&
          e_alu_result[MSB] != op_a[MSB]));

    assign e_cause      = (cause_q != mips_pkg::exc_none) ? cause_q :
                          overflow ? mips_pkg::exc_overflow : mips_pkg::exc_none;
    assign e_reg_write  = reg_write_q && (e_cause == mips_pkg::exc_none);
    assign e_mem_read   = mem_read_q && (e_cause == mips_pkg::exc_none);
    assign e_mem_write  = mem_write_q && (e_cause == mips_pkg::exc_none);
    assign e_store_data = op_b;

endmodule

// ==== hdl/memory_stage.sv ====
/* memory stage and data memory */

`timescale 1ns/1ps

module memory_stage
(
    input  logic                              SYS_clk,
    input  logic                              SYS_reset,
    input  logic                              flush,
    input  logic                              e_valid,
    input  logic [mips_pkg::XLEN-1:0]         e_alu_result,
    input  logic [mips_pkg::XLEN-1:0]         e_store_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   e_dest,
    input  logic                              e_mem_read,
    input  logic                              e_mem_write,
    input  logic                              e_reg_write,
    input  mips_pkg::exc_cause_t              e_cause,
    input  logic [mips_pkg::XLEN-1:0]         e_pc,
    output logic                              m_valid,
    output logic [mips_pkg::XLEN-1:0]         m_result,
    output logic [mips_pkg::XLEN-1:0]         m_alu_result,
    output logic [mips_pkg::REG_ADDR_W-1:0]   m_dest,
    output logic                              m_reg_write,
    output mips_pkg::exc_cause_t              m_cause,
    output logic [mips_pkg::XLEN-1:0]         m_pc
);

    logic [mips_pkg::XLEN-1:0]        dmem [mips_pkg::DMEM_WORDS];
    logic [mips_pkg::XLEN-1:0]        store_q;
    logic [mips_pkg::DMEM_ADDR_W-1:0] word_idx;
    mips_pkg::exc_cause_t             cause_q;
    logic                             mem_read_q;
    logic                             mem_write_q;
    logic                             reg_write_q;
    logic                             unaligned;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset || flush)
        begin
            m_valid     <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            reg_write_q <= 1'b0;
            cause_q     <= mips_pkg::exc_none;
        end
        else
        begin
            m_valid     <= e_valid;
            mem_read_q  <= e_mem_read;
            mem_write_q <= e_mem_write;
            reg_write_q <= e_reg_write;
            cause_q     <= e_cause;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        m_alu_result <= e_alu_result;
        store_q      <= e_store_data;
        m_dest       <= e_dest;
        m_pc         <= e_pc;
    end

    assign unaligned = (mem_read_q || mem_write_q) && (m_alu_result[1:0] != 2'b00);
    assign m_cause   = (cause_q != mips_pkg::exc_none) ? cause_q :
                       unaligned ? mips_pkg::exc_unaligned : mips_pkg::exc_none;
    assign m_reg_write = reg_write_q && (m_cause == mips_pkg::exc_none);
    assign word_idx  = m_alu_result[2 +: mips_pkg::DMEM_ADDR_W];  // wraps modulo depth

    // store killed by a flush from an older instruction
    always_ff @(posedge SYS_clk)
    begin
        if (mem_write_q && m_cause == mips_pkg::exc_none && !flush)
            dmem[word_idx] <= store_q;
    end

    assign m_result = mem_read_q ? dmem[word_idx] : m_alu_result;

endmodule

// ==== hdl/mips_core.sv ====
/* five-stage mips core */

`timescale 1ns/1ps

module mips_core
(
    input  logic                              SYS_clk,
    input  logic                              SYS_reset,
    input  logic                              instr_valid,
    input  logic [mips_pkg::XLEN-1:0]         instr,
    output logic                              wb_valid,
    output logic [mips_pkg::REG_ADDR_W-1:0]   wb_reg,
    output logic [mips_pkg::XLEN-1:0]         wb_data,
    output logic                              exc_valid,
    output mips_pkg::exc_cause_t              exc_cause,
    output logic [mips_pkg::XLEN-1:0]         epc
);

    logic                            flush;
    logic [mips_pkg::XLEN-1:0]       rf_rs_val;
    logic [mips_pkg::XLEN-1:0]       rf_rt_val;

    // decode outputs
    logic                            d_valid;
    mips_pkg::alu_op_t               d_alu_op;
    logic [mips_pkg::REG_ADDR_W-1:0] d_rs;
    logic [mips_pkg::REG_ADDR_W-1:0] d_rt;
    logic [mips_pkg::REG_ADDR_W-1:0] d_dest;
    logic [mips_pkg::XLEN-1:0]       d_imm;
    logic                            d_use_imm;
    logic                            d_mem_read;
    logic                            d_mem_write;
    logic                            d_reg_write;
    mips_pkg::exc_cause_t            d_cause;
    logic [mips_pkg::XLEN-1:0]       d_pc;
    logic [mips_pkg::XLEN-1:0]       d_rs_val;
    logic [mips_pkg::XLEN-1:0]       d_rt_val;

    // execute outputs
    logic                            e_valid;
    logic [mips_pkg::XLEN-1:0]       e_alu_result;
    logic [mips_pkg::XLEN-1:0]       e_store_data;
    logic [mips_pkg::REG_ADDR_W-1:0] e_dest;
    logic                            e_mem_read;
    logic                            e_mem_write;
    logic                            e_reg_write;
    mips_pkg::exc_cause_t            e_cause;
    logic [mips_pkg::XLEN-1:0]       e_pc;

    // memory outputs
    logic                            m_valid;
    logic [mips_pkg::XLEN-1:0]       m_result;
    logic [mips_pkg::XLEN-1:0]       m_alu_result;
    logic [mips_pkg::REG_ADDR_W-1:0] m_dest;
    logic                            m_reg_write;
    mips_pkg::exc_cause_t            m_cause;
    logic [mips_pkg::XLEN-1:0]       m_pc;

    decode_stage decode_stage_inst (.*, .rs_val(rf_rs_val), .rt_val(rf_rt_val));

    register_file register_file_inst
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (d_rs),
        .rt_addr   (d_rt),
        .wr_en     (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data),
        .rs_val    (rf_rs_val),
        .rt_val    (rf_rt_val)
    );

    execute_stage execute_stage_inst (.*);

    memory_stage memory_stage_inst (.*);

    writeback_stage writeback_stage_inst (.*);

endmodule

// ==== hdl/mips_pkg.sv ====
/* mips pipeline shared definitions */

package mips_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int REG_COUNT   = 32;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] PC_BASE = 32'h00400000;
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0]
    {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // function field of r-type, bits 5:0
    typedef enum logic [5:0]
    {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_t;

    typedef enum logic [2:0]
    {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [2:0]
    {
        exc_none       = 3'd0,
        exc_illegal    = 3'd1,  // decode
        exc_overflow   = 3'd2,  // execute
        exc_unaligned  = 3'd3,  // memory
        exc_zero_write = 3'd7   // writeback
    } exc_cause_t;

endpackage

// ==== hdl/register_file.sv ====
/* general register file */

`timescale 1ns/1ps

module register_file
(
    input  logic                              SYS_clk,
    input  logic                              SYS_reset,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rs_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rt_addr,
    input  logic                              wr_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   wr_addr,
    input  logic [mips_pkg::XLEN-1:0]         wr_data,
    output logic [mips_pkg::XLEN-1:0]         rs_val,
    output logic [mips_pkg::XLEN-1:0]         rt_val
);

    logic [mips_pkg::XLEN-1:0] regs [mips_pkg::REG_COUNT];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < mips_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // r0 reads zero, pending write bypasses the array
    assign rs_val = (rs_addr == '0) ? '0 :
                    (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_val = (rt_addr == '0) ? '0 :
                    (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

    // writeback turns r0 writes into exceptions
    a_no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(wr_en && wr_addr == '0));

endmodule

// ==== hdl/writeback_stage.sv ====
/* writeback and exception commit */

`timescale 1ns/1ps

module writeback_stage
(
    input  logic                              SYS_clk,
    input  logic                              SYS_reset,
    input  logic                              m_valid,
    input  logic [mips_pkg::XLEN-1:0]         m_result,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   m_dest,
    input  logic                              m_reg_write,
    input  mips_pkg::exc_cause_t              m_cause,
    input  logic [mips_pkg::XLEN-1:0]         m_pc,
    output logic                              wb_valid,
    output logic [mips_pkg::REG_ADDR_W-1:0]   wb_reg,
    output logic [mips_pkg::XLEN-1:0]         wb_data,
    output logic                              exc_valid,
    output mips_pkg::exc_cause_t              exc_cause,
    output logic [mips_pkg::XLEN-1:0]         epc,
    output logic                              flush
);

    logic                 valid_q;
    logic                 reg_write_q;
    mips_pkg::exc_cause_t cause_q;

    // the instruction behind an exception is dropped here too
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset || exc_valid)
        begin
            valid_q     <= 1'b0;
            reg_write_q <= 1'b0;
            cause_q     <= mips_pkg::exc_none;
        end
        else
        begin
            valid_q     <= m_valid;
            reg_write_q <= m_reg_write;
            cause_q     <= m_cause;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_reg  <= m_dest;
        wb_data <= m_result;
        epc     <= m_pc;
    end

    assign exc_cause = (cause_q != mips_pkg::exc_none) ? cause_q :
                       (reg_write_q && wb_reg == '0) ? mips_pkg::exc_zero_write :
                       mips_pkg::exc_none;
    assign exc_valid = valid_q && (exc_cause != mips_pkg::exc_none);
    assign wb_valid  = valid_q && reg_write_q && (exc_cause == mips_pkg::exc_none);
    assign flush     = exc_valid;

    // exception report lasts a single cycle
    a_exc_pulse: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid |=> !exc_valid);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the mips_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mips_core -f tb.f -o sim_tb_mips_core
./obj_dir/sim_tb_mips_core > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tb.f ====
hdl/mips_pkg.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/writeback_stage.sv
hdl/mips_core.sv
tb/tb_mips_core.sv

// ==== tb/tb_mips_core.sv ====
/* mips core testbench */

`timescale 1ns/1ps

module tb_mips_core;

    typedef enum {kind_write, kind_none, kind_exc} kind_t;

    typedef struct {
        string                           name;
        logic [31:0]                     word;
        kind_t                           kind;
        logic [mips_pkg::REG_ADDR_W-1:0] rd;
        logic [mips_pkg::XLEN-1:0]       data;
        mips_pkg::exc_cause_t            cause;
        bit                              tight;  // issued with no idle before it
    } entry_t;

    typedef struct {
        entry_t                    ent;
        int                        issue;
        logic [mips_pkg::XLEN-1:0] pc;
        bit                        killed;
    } pending_t;

    logic                            SYS_clk;
    logic                            SYS_reset;
    logic                            instr_valid;
    logic [mips_pkg::XLEN-1:0]       instr;
    logic                            wb_valid;
    logic [mips_pkg::REG_ADDR_W-1:0] wb_reg;
    logic [mips_pkg::XLEN-1:0]       wb_data;
    logic                            exc_valid;
    mips_pkg::exc_cause_t            exc_cause;
    logic [mips_pkg::XLEN-1:0]       epc;

    entry_t      stim_table[$];
    pending_t    expect_q[$];
    int          edge_cnt = 0;
    int          cycle_limit = 0;
    logic [31:0] lfsr_state = 32'hc583;

    mips_core mips_core_inst
    (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause),
        .epc         (epc)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever
        begin
            #20;
            edge_cnt++;  // counted before the edge so waiters see it
            SYS_clk = 1'b1;
            #20;
            SYS_clk = 1'b0;
        end
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] r_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                           mips_pkg::funct_t fn);
        return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_word(mips_pkg::opcode_t op, logic [4:0] rs,
                                           logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic add_entry(string name, logic [31:0] word, kind_t kind, logic [4:0] rd,
                             logic [31:0] data, mips_pkg::exc_cause_t cause, bit tight);
        entry_t e;
        e.name  = name;
        e.word  = word;
        e.kind  = kind;
        e.rd    = rd;
        e.data  = data;
        e.cause = cause;
        e.tight = tight;
        stim_table.push_back(e);
    endtask

    task automatic write_entry(string name, logic [31:0] word, logic [4:0] rd,
                               logic [31:0] data, bit tight);
        add_entry(name, word, kind_write, rd, data, mips_pkg::exc_none, tight);
    endtask

    task automatic exception_entry(string name, logic [31:0] word,
                                   mips_pkg::exc_cause_t cause);
        add_entry(name, word, kind_exc, 5'd0, '0, cause, 1'b0);
    endtask

    task automatic silent_entry(string name, logic [31:0] word);
        add_entry(name, word, kind_none, 5'd0, '0, mips_pkg::exc_none, 1'b0);
    endtask

    // independent writes, killed or not depending on the idle gaps
    task automatic append_fillers();
        for (int i = 0; i < 4; i++)
            write_entry($sformatf("fill_%0d", i),
                        i_word(mips_pkg::op_addi, 5'd0, 5'(22 + i), 16'(17 * (i + 1))),
                        5'(22 + i), 32'(17 * (i + 1)), 1'b0);
    endtask

    task automatic build_table();
        write_entry("addi_pos", i_word(mips_pkg::op_addi, 5'd0, 5'd1, 16'd100), 5'd1, 32'd100, 0);
        write_entry("addi_neg", i_word(mips_pkg::op_addi, 5'd0, 5'd2, 16'hfff9), 5'd2,
                    32'hfffffff9, 0);
        write_entry("addi_f0", i_word(mips_pkg::op_addi, 5'd0, 5'd3, 16'h00f0), 5'd3, 32'hf0, 0);
        write_entry("addi_3c", i_word(mips_pkg::op_addi, 5'd0, 5'd4, 16'h003c), 5'd4, 32'h3c, 0);
        write_entry("add", r_word(5'd1, 5'd2, 5'd5, mips_pkg::fn_add), 5'd5, 32'd93, 0);
        write_entry("sub", r_word(5'd1, 5'd2, 5'd6, mips_pkg::fn_sub), 5'd6, 32'd107, 0);
        write_entry("and", r_word(5'd3, 5'd4, 5'd7, mips_pkg::fn_and), 5'd7, 32'h30, 0);
        write_entry("or", r_word(5'd3, 5'd4, 5'd8, mips_pkg::fn_or), 5'd8, 32'hfc, 0);
        write_entry("slt_neg", r_word(5'd2, 5'd1, 5'd9, mips_pkg::fn_slt), 5'd9, 32'd1, 0);
        write_entry("slt_pos", r_word(5'd1, 5'd2, 5'd10, mips_pkg::fn_slt), 5'd10, 32'd0, 0);
        // dependency chain at distances 1, 2 and 3
        write_entry("fwd_seed", i_word(mips_pkg::op_addi, 5'd0, 5'd11, 16'd5), 5'd11, 32'd5, 0);
        write_entry("fwd_d1", i_word(mips_pkg::op_addi, 5'd11, 5'd12, 16'd3), 5'd12, 32'd8, 1);
        write_entry("fwd_d2", r_word(5'd11, 5'd12, 5'd13, mips_pkg::fn_add), 5'd13, 32'd13, 1);
        write_entry("fwd_d3", r_word(5'd13, 5'd11, 5'd14, mips_pkg::fn_sub), 5'd14, 32'd8, 1);
        write_entry("fwd_or", r_word(5'd14, 5'd13, 5'd15, mips_pkg::fn_or), 5'd15, 32'd13, 1);
        write_entry("base", i_word(mips_pkg::op_addi, 5'd0, 5'd16, 16'h40), 5'd16, 32'h40, 0);
        write_entry("sdata", i_word(mips_pkg::op_addi, 5'd0, 5'd17, 16'h1234), 5'd17,
                    32'h1234, 0);
        silent_entry("sw", i_word(mips_pkg::op_sw, 5'd16, 5'd17, 16'd4));
        write_entry("spacer", r_word(5'd1, 5'd1, 5'd18, mips_pkg::fn_add), 5'd18, 32'd200, 0);
        write_entry("lw", i_word(mips_pkg::op_lw, 5'd16, 5'd19, 16'd4), 5'd19, 32'h1234, 0);
        write_entry("delay_slot", i_word(mips_pkg::op_addi, 5'd0, 5'd20, 16'd1), 5'd20, 32'd1, 1);
        write_entry("use_load", r_word(5'd19, 5'd19, 5'd21, mips_pkg::fn_add), 5'd21,
                    32'h2468, 1);
        silent_entry("nop", 32'h0);
        exception_entry("illegal_op", 32'hfc000000, mips_pkg::exc_illegal);
        append_fillers();
        write_entry("ovf_seed", i_word(mips_pkg::op_addi, 5'd0, 5'd26, 16'h4000), 5'd26,
                    32'h4000, 0);
        for (int i = 1; i <= 16; i++)
            write_entry($sformatf("double_%0d", i), r_word(5'd26, 5'd26, 5'd26, mips_pkg::fn_add),
                        5'd26, 32'h4000 << i, 0);
        exception_entry("add_overflow", r_word(5'd26, 5'd26, 5'd27, mips_pkg::fn_add),
                        mips_pkg::exc_overflow);
        append_fillers();
        exception_entry("lw_unaligned", i_word(mips_pkg::op_lw, 5'd16, 5'd28, 16'd2),
                        mips_pkg::exc_unaligned);
        append_fillers();
        exception_entry("addi_r0", i_word(mips_pkg::op_addi, 5'd0, 5'd0, 16'd5),
                        mips_pkg::exc_zero_write);
        append_fillers();
    endtask

    task automatic compare_write(string name, logic [mips_pkg::REG_ADDR_W-1:0] exp_reg,
                                 logic [mips_pkg::XLEN-1:0] exp_data);
        if (!wb_valid)
            abort_run($sformatf("%s: no register write where one was expected", name));
        else if (wb_reg !== exp_reg || wb_data !== exp_data)
            abort_run($sformatf("MISMATCH %s: expected r%0d = %h, actual r%0d = %h",
                                name, exp_reg, exp_data, wb_reg, wb_data));
    endtask

    task automatic compare_exception(string name, mips_pkg::exc_cause_t exp_cause,
                                     logic [mips_pkg::XLEN-1:0] exp_pc);
        if (!exc_valid)
            abort_run($sformatf("%s: no exception where one was expected", name));
        else if (exc_cause !== exp_cause || epc !== exp_pc)
            abort_run($sformatf("MISMATCH %s: expected %s at %h, actual %s at %h",
                                name, exp_cause.name(), exp_pc, exc_cause.name(), epc));
    endtask

    task automatic require_idle(string name);
        if (wb_valid)
            abort_run($sformatf("%s: unexpected register write to r%0d", name, wb_reg));
        else if (exc_valid)
            abort_run($sformatf("%s: unexpected exception at %h", name, epc));
    endtask

    always @(posedge SYS_clk)
    begin
        if (cycle_limit > 0 && edge_cnt > cycle_limit)
            abort_run("timeout: pipeline results did not drain in time");
    end

    // outputs are stable mid-cycle
    always @(negedge SYS_clk)
    begin : commit_check
        pending_t p;
        if (!SYS_reset)
        begin
            if (expect_q.size() != 0 && expect_q[0].issue + 3 == edge_cnt)
            begin
                p = expect_q.pop_front();
                if (p.killed || p.ent.kind == kind_none)
                    require_idle(p.ent.name);
                else if (p.ent.kind == kind_write)
                    compare_write(p.ent.name, p.ent.rd, p.ent.data);
                else
                    compare_exception(p.ent.name, p.ent.cause, p.pc);
            end
            else
                require_idle("idle slot");
        end
    end

    initial
    begin
        entry_t                    ent;
        pending_t                  pend;
        logic [1:0]                gap_bits;
        logic [mips_pkg::XLEN-1:0] model_pc;
        int                        issue;
        int                        kill_from;
        int                        kill_to;
        int                        pc_reset_edge;
        SYS_reset     = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        model_pc      = mips_pkg::PC_BASE;
        kill_from     = -1;
        kill_to       = -1;
        pc_reset_edge = -1;
        build_table();
        cycle_limit = stim_table.size() * 3 + 20;
        repeat (2) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        foreach (stim_table[i])
        begin
            ent = stim_table[i];
            gap_bits = 2'd0;
            if (!ent.tight)
            begin
                repeat (2)
                begin
                    lfsr_state = lfsr_step(lfsr_state);
                    gap_bits = {gap_bits[0], lfsr_state[0]};
                end
            end
            repeat (int'(gap_bits) % 3)
            begin
                @(posedge SYS_clk);
                instr_valid <= 1'b0;
                instr       <= '0;
            end
            @(posedge SYS_clk);
            instr_valid <= 1'b1;
            instr       <= ent.word;
            issue = edge_cnt + 1;  // sampled on the next edge
            if (pc_reset_edge >= 0 && issue > pc_reset_edge)
            begin
                model_pc      = mips_pkg::PC_BASE;  // counter cleared by the flush
                pc_reset_edge = -1;
            end
            pend.ent    = ent;
            pend.issue  = issue;
            pend.pc     = model_pc;
            pend.killed = (issue >= kill_from && issue <= kill_to);
            model_pc    = model_pc + mips_pkg::PC_STEP;
            if (!pend.killed && ent.kind == kind_exc)
            begin
                kill_from     = issue + 1;
                kill_to       = issue + 4;
                pc_reset_edge = issue + 4;
            end
            expect_q.push_back(pend);
        end
        @(posedge SYS_clk);
        instr_valid <= 1'b0;
        instr       <= '0;
        while (expect_q.size() != 0)
            @(posedge SYS_clk);
        repeat (2) @(posedge SYS_clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
